/* common/soc_ctrl_pkg.sv */
/*
 * shared definitions of the SoC control register block
 *  - typedefs for APB address, data word, register index,
 *    pad function select and cluster boot address
 *  - register word indices, taken from byte address bits 8:2
 *  - reset constants and pad packing per register word
 */
package soc_ctrl_pkg;

   typedef logic [11:0] apb_addr_t;      // 4 kB slave window
   typedef logic [31:0] word_t;
   typedef logic  [6:0] reg_idx_t;       // PADDR[8:2]
   typedef logic  [1:0] pad_fun_t;       // alternate function of one pad
   typedef logic [63:0] cluster_boot_t;

   // chip identification and fabric controller
   localparam reg_idx_t REG_INFO          = 7'd0;   // cores [31:16], clusters [15:0]
   localparam reg_idx_t REG_FCBOOT        = 7'd1;   // fc boot address
   localparam reg_idx_t REG_FCFETCH       = 7'd2;   // fc fetch enable, write only

   // four words of 16 pads, two select bits per pad
   localparam reg_idx_t REG_PADFUN_BASE   = 7'd4;

   // sixteen words of 4 pads, one byte per pad
   // byte layout of one pad
   //   bit 0    pull-up enable
   //   bit 1    pull-down enable
   //   bit 2    schmitt trigger enable
   //   bit 3    slew rate limit
   //   bits 5:4 drive strength
   localparam reg_idx_t REG_PADCFG_BASE   = 7'd8;

   // cluster control
   localparam reg_idx_t REG_CLUSTER_CTRL  = 7'd28;  // byp, pow, fetch, rstn
   localparam reg_idx_t REG_JTAGREG       = 7'd29;  // jtag exchange word
   localparam reg_idx_t REG_CLUSTER_IRQ   = 7'd31;
   localparam reg_idx_t REG_CLUSTER_BOOT0 = 7'd32;  // boot address low word
   localparam reg_idx_t REG_CLUSTER_BOOT1 = 7'd33;  // boot address high word

   // status and sampled pins
   localparam reg_idx_t REG_CORESTATUS    = 7'd40;  // eoc in bit 31, status below
   localparam reg_idx_t REG_CS_RO         = 7'd48;  // read only mirror
   localparam reg_idx_t REG_BOOTSEL       = 7'd49;
   localparam reg_idx_t REG_CLKSEL        = 7'd50;

   // fc starts from the boot rom entry
   localparam word_t FC_BOOT_ADDR_RST = 32'h1A00_0080;

   // packing of pads into register words
   localparam int unsigned PADS_PER_FUN_WORD = 16;
   localparam int unsigned PADS_PER_CFG_WORD = 4;

endpackage

/* pads/pad_mux_regs.sv */
/*
 * pad function select registers
 *  - two select bits per pad, 16 pads per APB word
 *  - write decode, read-back and pad_mux output
 *  - check that selects only move on an APB write
 */
`timescale 1ns/100ps

module pad_mux_regs #(
   parameter int unsigned NUM_PADS = 64
) (
   input  logic                                  HCLK,
   input  logic                                  HRESETn,
   input  soc_ctrl_pkg::reg_idx_t                reg_idx_i,
   input  logic                                  wr_en_i,
   input  soc_ctrl_pkg::word_t                   wdata_i,
   output soc_ctrl_pkg::word_t                   rdata_o,
   output soc_ctrl_pkg::pad_fun_t [NUM_PADS-1:0] pad_mux_o
);
   import soc_ctrl_pkg::*;

   localparam int unsigned NUM_FUN_WORDS = NUM_PADS / PADS_PER_FUN_WORD;

   pad_fun_t [NUM_PADS-1:0] r_pad_fun;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
         r_pad_fun <= '0;  // all pads on their default function
      else if (wr_en_i)
      begin
         for (int k = 0; k < NUM_FUN_WORDS; k++)
            if (reg_idx_i == reg_idx_t'(REG_PADFUN_BASE + k))
               for (int i = 0; i < PADS_PER_FUN_WORD; i++)
                  r_pad_fun[k*PADS_PER_FUN_WORD+i] <= wdata_i[2*i +: 2];
      end
   end

   always_comb
   begin
      rdata_o = '0;
      for (int k = 0; k < NUM_FUN_WORDS; k++)
         if (reg_idx_i == reg_idx_t'(REG_PADFUN_BASE + k))
            for (int i = 0; i < PADS_PER_FUN_WORD; i++)
               rdata_o[2*i +: 2] = r_pad_fun[k*PADS_PER_FUN_WORD+i];
   end

   assign pad_mux_o = r_pad_fun;

   // a pad must never switch function on its own
   a_mux_only_on_write : assert property (
      @(posedge HCLK) disable iff (!HRESETn)
      !$past(wr_en_i) |-> $stable(pad_mux_o)
   );

endmodule

/* pads/pad_cfg_regs.sv */
/*
 * pad configuration registers
 *  - one byte per pad, 4 pads per APB word
 *  - low NBIT_PADCFG bits of each byte are stored, the rest read zero
 *  - write decode, read-back and pad_cfg output
 *  - check of the all-ones reset value
 */
`timescale 1ns/100ps

module pad_cfg_regs #(
   parameter int unsigned NUM_PADS    = 64,
   parameter int unsigned NBIT_PADCFG = 6
) (
   input  logic                                    HCLK,
   input  logic                                    HRESETn,
   input  soc_ctrl_pkg::reg_idx_t                  reg_idx_i,
   input  logic                                    wr_en_i,
   input  soc_ctrl_pkg::word_t                     wdata_i,
   output soc_ctrl_pkg::word_t                     rdata_o,
   output logic [NUM_PADS-1:0][NBIT_PADCFG-1:0]    pad_cfg_o
);
   import soc_ctrl_pkg::*;

   localparam int unsigned NUM_CFG_WORDS = NUM_PADS / PADS_PER_CFG_WORD;

   logic [NUM_PADS-1:0][NBIT_PADCFG-1:0] r_pad_cfg;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
         r_pad_cfg <= '1;  // pulls, st and full drive on
      else if (wr_en_i)
      begin
         for (int k = 0; k < NUM_CFG_WORDS; k++)
            if (reg_idx_i == reg_idx_t'(REG_PADCFG_BASE + k))
               for (int i = 0; i < PADS_PER_CFG_WORD; i++)
                  r_pad_cfg[k*PADS_PER_CFG_WORD+i] <= wdata_i[8*i +: NBIT_PADCFG];
      end
   end

   always_comb
   begin
      rdata_o = '0;  // unused upper bits of each byte stay zero
      for (int k = 0; k < NUM_CFG_WORDS; k++)
         if (reg_idx_i == reg_idx_t'(REG_PADCFG_BASE + k))
            for (int i = 0; i < PADS_PER_CFG_WORD; i++)
               rdata_o[8*i +: NBIT_PADCFG] = r_pad_cfg[k*PADS_PER_CFG_WORD+i];
   end

   assign pad_cfg_o = r_pad_cfg;

   // pads come out of reset fully configured
   a_cfg_reset_ones : assert property (
      @(posedge HCLK)
      $rose(HRESETn) |-> (pad_cfg_o == '1)
   );

endmodule

/* rtl/boot_ctrl_regs.sv */
/*
 * fabric controller and cluster boot/control registers
 *  - fc boot address and fetch enable with external override
 *  - cluster bypass, power, fetch enable, reset and irq bits
 *  - 64-bit cluster boot address over two APB words
 */
`timescale 1ns/100ps

module boot_ctrl_regs (
   input  logic                        HCLK,
   input  logic                        HRESETn,
   input  soc_ctrl_pkg::reg_idx_t      reg_idx_i,
   input  logic                        wr_en_i,
   input  soc_ctrl_pkg::word_t         wdata_i,
   input  logic                        fc_fetch_en_valid_i,
   input  logic                        fc_fetch_en_i,
   output soc_ctrl_pkg::word_t         rdata_o,
   output soc_ctrl_pkg::word_t         fc_bootaddr_o,
   output logic                        fc_fetchen_o,
   output logic                        cluster_byp_o,
   output logic                        cluster_pow_o,
   output logic                        cluster_fetch_enable_o,
   output logic                        cluster_rstn_o,
   output logic                        cluster_irq_o,
   output soc_ctrl_pkg::cluster_boot_t cluster_boot_addr_o
);
   import soc_ctrl_pkg::*;

   word_t         r_bootaddr;
   logic          r_fetchen;
   logic    [3:0] r_cluster_ctrl;  // {rstn, fetch, pow, byp}
   logic          r_cluster_irq;
   cluster_boot_t r_cluster_boot;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_bootaddr     <= FC_BOOT_ADDR_RST;
         r_cluster_ctrl <= 4'b1001;  // out of reset, bypassed, unpowered
         r_cluster_irq  <= 1'b0;
         r_cluster_boot <= '0;
      end
      else if (wr_en_i)
      begin
         case (reg_idx_i)
            REG_FCBOOT:        r_bootaddr            <= wdata_i;
            REG_CLUSTER_CTRL:  r_cluster_ctrl        <= wdata_i[3:0];
            REG_CLUSTER_IRQ:   r_cluster_irq         <= wdata_i[0];
            REG_CLUSTER_BOOT0: r_cluster_boot[31:0]  <= wdata_i;
            REG_CLUSTER_BOOT1: r_cluster_boot[63:32] <= wdata_i;
            default: ;
         endcase
      end
   end

   // fc stays idle until told to fetch
   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
         r_fetchen <= 1'b0;
      else if (wr_en_i && (reg_idx_i == REG_FCFETCH))
         r_fetchen <= wdata_i[0];  // apb write beats the override
      else if (fc_fetch_en_valid_i)
         r_fetchen <= fc_fetch_en_i;
   end

   always_comb
   begin
      case (reg_idx_i)
         REG_FCBOOT:        rdata_o = r_bootaddr;
         REG_CLUSTER_CTRL:  rdata_o = {28'h0, r_cluster_ctrl};
         REG_CLUSTER_IRQ:   rdata_o = {31'h0, r_cluster_irq};
         REG_CLUSTER_BOOT0: rdata_o = r_cluster_boot[31:0];
         REG_CLUSTER_BOOT1: rdata_o = r_cluster_boot[63:32];
         default:           rdata_o = '0;  // fetch enable reads zero too
      endcase
   end

   assign fc_bootaddr_o          = r_bootaddr;
   assign fc_fetchen_o           = r_fetchen;
   assign cluster_byp_o          = r_cluster_ctrl[0];
   assign cluster_pow_o          = r_cluster_ctrl[1];
   assign cluster_fetch_enable_o = r_cluster_ctrl[2];
   assign cluster_rstn_o         = r_cluster_ctrl[3];
   assign cluster_irq_o          = r_cluster_irq;
   assign cluster_boot_addr_o    = r_cluster_boot;

endmodule

/* rtl/status_regs.sv */
/*
 * status and identification registers
 *  - info word with core and cluster counts
 *  - core status with its read-only mirror
 *  - sampled boot select and clock select pins
 *  - jtag exchange word with two-stage input synchronizer
 */
`timescale 1ns/100ps

module status_regs #(
   parameter int unsigned JTAG_REG_SIZE = 8,
   parameter int unsigned NB_CORES      = 4,
   parameter int unsigned NB_CLUSTERS   = 1
) (
   input  logic                     HCLK,
   input  logic                     HRESETn,
   input  soc_ctrl_pkg::reg_idx_t   reg_idx_i,
   input  logic                     wr_en_i,
   input  soc_ctrl_pkg::word_t      wdata_i,
   input  logic                     sel_fll_clk_i,
   input  logic               [1:0] bootsel_i,
   input  logic [JTAG_REG_SIZE-1:0] soc_jtag_reg_i,
   output soc_ctrl_pkg::word_t      rdata_o,
   output logic [JTAG_REG_SIZE-1:0] soc_jtag_reg_o
);
   import soc_ctrl_pkg::*;

   word_t                         r_corestatus;
   logic                    [1:0] r_bootsel;
   logic      [JTAG_REG_SIZE-1:0] r_jtag_rego;
   logic [1:0][JTAG_REG_SIZE-1:0] r_jtag_sync;  // [1] is the safe stage

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_corestatus <= '0;
         r_jtag_rego  <= '0;
         r_jtag_sync  <= '0;
         r_bootsel    <= '0;
      end
      else
      begin
         r_jtag_sync <= {r_jtag_sync[0], soc_jtag_reg_i};  // tck domain crossing
         r_bootsel   <= bootsel_i;
         if (wr_en_i && (reg_idx_i == REG_CORESTATUS))
            r_corestatus <= wdata_i;
         if (wr_en_i && (reg_idx_i == REG_JTAGREG))
            r_jtag_rego <= wdata_i[JTAG_REG_SIZE-1:0];
      end
   end

   always_comb
   begin
      rdata_o = '0;
      case (reg_idx_i)
         REG_INFO:       rdata_o = {16'(NB_CORES), 16'(NB_CLUSTERS)};
         REG_CORESTATUS: rdata_o = r_corestatus;
         REG_CS_RO:      rdata_o = r_corestatus;  // mirror, writes ignored
         REG_BOOTSEL:    rdata_o[1:0] = r_bootsel;
         REG_CLKSEL:     rdata_o[0] = sel_fll_clk_i;
         REG_JTAGREG:
         begin
            rdata_o[JTAG_REG_SIZE-1:0]  = r_jtag_rego;
            rdata_o[8 +: JTAG_REG_SIZE] = r_jtag_sync[1];
         end
         default: ;
      endcase
   end

   assign soc_jtag_reg_o = r_jtag_rego;

endmodule

/* rtl/apb_soc_ctrl.sv */
/*
 * APB system control register block, top level
 *  - address decode to register word index and write strobe
 *  - pad, boot/cluster and status register blocks
 *  - read-data merge, zero-wait-state handshake
 *  - parameter range checks and read-data check
 */
`timescale 1ns/100ps

module apb_soc_ctrl #(
   parameter int unsigned NUM_PADS      = 64,
   parameter int unsigned NBIT_PADCFG   = 6,
   parameter int unsigned JTAG_REG_SIZE = 8,
   parameter int unsigned NB_CORES      = 4,
   parameter int unsigned NB_CLUSTERS   = 1
) (
   input  logic                                  HCLK,
   input  logic                                  HRESETn,
   input  soc_ctrl_pkg::apb_addr_t               PADDR_i,
   input  soc_ctrl_pkg::word_t                   PWDATA_i,
   input  logic                                  PWRITE_i,
   input  logic                                  PSEL_i,
   input  logic                                  PENABLE_i,
   output soc_ctrl_pkg::word_t                   PRDATA_o,
   output logic                                  PREADY_o,
   output logic                                  PSLVERR_o,

   input  logic                                  sel_fll_clk_i,
   input  logic                            [1:0] bootsel_i,
   input  logic                                  fc_fetch_en_valid_i,
   input  logic                                  fc_fetch_en_i,
   input  logic              [JTAG_REG_SIZE-1:0] soc_jtag_reg_i,

   output soc_ctrl_pkg::pad_fun_t [NUM_PADS-1:0] pad_mux_o,
   output logic  [NUM_PADS-1:0][NBIT_PADCFG-1:0] pad_cfg_o,
   output logic              [JTAG_REG_SIZE-1:0] soc_jtag_reg_o,
   output soc_ctrl_pkg::word_t                   fc_bootaddr_o,
   output logic                                  fc_fetchen_o,
   output logic                                  cluster_pow_o,
   output logic                                  cluster_byp_o,
   output soc_ctrl_pkg::cluster_boot_t           cluster_boot_addr_o,
   output logic                                  cluster_fetch_enable_o,
   output logic                                  cluster_rstn_o,
   output logic                                  cluster_irq_o
);
   import soc_ctrl_pkg::*;

   reg_idx_t reg_idx;
   logic     wr_en;
   word_t    rd_pad_mux;
   word_t    rd_pad_cfg;
   word_t    rd_boot;
   word_t    rd_status;

   if ((NUM_PADS % 16 != 0) || (NUM_PADS < 16) || (NUM_PADS > 64))
      $error("apb_soc_ctrl: NUM_PADS must be a multiple of 16 in 16..64");
   if ((NBIT_PADCFG < 3) || (NBIT_PADCFG > 8))
      $error("apb_soc_ctrl: NBIT_PADCFG must be in 3..8");
   if ((JTAG_REG_SIZE < 1) || (JTAG_REG_SIZE > 8))
      $error("apb_soc_ctrl: JTAG_REG_SIZE must be in 1..8");

   assign reg_idx = PADDR_i[8:2];                      // word index
   assign wr_en   = PSEL_i && PENABLE_i && PWRITE_i;   // access phase write

   pad_mux_regs #(
      .NUM_PADS (NUM_PADS)
   ) u_pad_mux (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .reg_idx_i (reg_idx),
      .wr_en_i   (wr_en),
      .wdata_i   (PWDATA_i),
      .rdata_o   (rd_pad_mux),
      .pad_mux_o (pad_mux_o)
   );

   pad_cfg_regs #(
      .NUM_PADS    (NUM_PADS),
      .NBIT_PADCFG (NBIT_PADCFG)
   ) u_pad_cfg (
      .HCLK      (HCLK),
      .HRESETn   (HRESETn),
      .reg_idx_i (reg_idx),
      .wr_en_i   (wr_en),
      .wdata_i   (PWDATA_i),
      .rdata_o   (rd_pad_cfg),
      .pad_cfg_o (pad_cfg_o)
   );

   boot_ctrl_regs u_boot_ctrl (
      .HCLK                   (HCLK),
      .HRESETn                (HRESETn),
      .reg_idx_i              (reg_idx),
      .wr_en_i                (wr_en),
      .wdata_i                (PWDATA_i),
      .fc_fetch_en_valid_i    (fc_fetch_en_valid_i),
      .fc_fetch_en_i          (fc_fetch_en_i),
      .rdata_o                (rd_boot),
      .fc_bootaddr_o          (fc_bootaddr_o),
      .fc_fetchen_o           (fc_fetchen_o),
      .cluster_byp_o          (cluster_byp_o),
      .cluster_pow_o          (cluster_pow_o),
      .cluster_fetch_enable_o (cluster_fetch_enable_o),
      .cluster_rstn_o         (cluster_rstn_o),
      .cluster_irq_o          (cluster_irq_o),
      .cluster_boot_addr_o    (cluster_boot_addr_o)
   );

   status_regs #(
      .JTAG_REG_SIZE (JTAG_REG_SIZE),
      .NB_CORES      (NB_CORES),
      .NB_CLUSTERS   (NB_CLUSTERS)
   ) u_status (
      .HCLK           (HCLK),
      .HRESETn        (HRESETn),
      .reg_idx_i      (reg_idx),
      .wr_en_i        (wr_en),
      .wdata_i        (PWDATA_i),
      .sel_fll_clk_i  (sel_fll_clk_i),
      .bootsel_i      (bootsel_i),
      .soc_jtag_reg_i (soc_jtag_reg_i),
      .rdata_o        (rd_status),
      .soc_jtag_reg_o (soc_jtag_reg_o)
   );

   // each block returns zero outside its own words
   assign PRDATA_o  = rd_pad_mux | rd_pad_cfg | rd_boot | rd_status;
   assign PREADY_o  = 1'b1;  // no wait states
   assign PSLVERR_o = 1'b0;

   // merged read data must be clean whenever the slave is selected
   a_prdata_known : assert property (
      @(posedge HCLK) disable iff (!HRESETn)
      PSEL_i |-> !$isunknown(PRDATA_o)
   );

endmodule

/* bench/tb_vectors.svh */
/*
 * stimulus and expected values of the APB register block testbench
 *  - entry layout and output checkpoint codes
 *  - table of APB transfers in the order they run
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
   logic       wr;     // 1 write, 0 read
   apb_addr_t  addr;   // byte address
   word_t      wdata;
   word_t      exp;    // expected read data
   word_t      mask;   // PRDATA bits compared
   logic [2:0] cp;     // output checkpoint after the entry
} vec_t;

localparam logic WR = 1'b1;
localparam logic RD = 1'b0;

localparam logic [2:0] CP_NONE   = 3'd0;
localparam logic [2:0] CP_RESET  = 3'd1;
localparam logic [2:0] CP_PADMUX = 3'd2;
localparam logic [2:0] CP_PADCFG = 3'd3;
localparam logic [2:0] CP_BOOT   = 3'd4;
localparam logic [2:0] CP_FETCH  = 3'd5;
localparam logic [2:0] CP_JTAG   = 3'd6;

localparam int unsigned NUM_VEC = 63;

// flag, addr, wdata, expected, mask, checkpoint
vec_t vectors [NUM_VEC] = '{
   '{RD, 12'h000, 32'h0000_0000, 32'h0004_0001, 32'hFFFF_FFFF, CP_RESET},   // info
   '{RD, 12'h004, 32'h0000_0000, 32'h1A00_0080, 32'hFFFF_FFFF, CP_NONE},    // fc boot
   '{RD, 12'h070, 32'h0000_0000, 32'h0000_0009, 32'hFFFF_FFFF, CP_NONE},    // byp and rstn
   '{RD, 12'h020, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},    // pad cfg words
   '{RD, 12'h024, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h028, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h02C, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h030, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h034, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h038, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h03C, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h040, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h044, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h048, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h04C, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h050, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h054, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h058, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h05C, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{WR, 12'h010, 32'h1B1B_1B1B, 32'h0000_0000, 32'h0000_0000, CP_NONE},    // pad function
   '{WR, 12'h014, 32'hE4E4_E4E4, 32'h0000_0000, 32'h0000_0000, CP_NONE},
   '{WR, 12'h018, 32'h5A5A_A5A5, 32'h0000_0000, 32'h0000_0000, CP_NONE},
   '{WR, 12'h01C, 32'hFFFF_0000, 32'h0000_0000, 32'h0000_0000, CP_PADMUX},
   '{RD, 12'h010, 32'h0000_0000, 32'h1B1B_1B1B, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h014, 32'h0000_0000, 32'hE4E4_E4E4, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h018, 32'h0000_0000, 32'h5A5A_A5A5, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h01C, 32'h0000_0000, 32'hFFFF_0000, 32'hFFFF_FFFF, CP_NONE},
   '{WR, 12'h020, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000, CP_NONE},    // pad config
   '{WR, 12'h03C, 32'h1234_5678, 32'h0000_0000, 32'h0000_0000, CP_NONE},
   '{WR, 12'h05C, 32'hA5C3_0F3C, 32'h0000_0000, 32'h0000_0000, CP_PADCFG},
   '{RD, 12'h020, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h03C, 32'h0000_0000, 32'h1234_1638, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h05C, 32'h0000_0000, 32'h2503_0F3C, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h024, 32'h0000_0000, 32'h3F3F_3F3F, 32'hFFFF_FFFF, CP_NONE},    // untouched word
   '{WR, 12'h004, 32'h1C00_8000, 32'h0000_0000, 32'h0000_0000, CP_NONE},    // boot and cluster
   '{WR, 12'h070, 32'h0000_0006, 32'h0000_0000, 32'h0000_0000, CP_NONE},
   '{WR, 12'h07C, 32'h0000_0001, 32'h0000_0000, 32'h0000_0000, CP_NONE},
   '{WR, 12'h080, 32'hDEAD_BEEF, 32'h0000_0000, 32'h0000_0000, CP_NONE},
   '{WR, 12'h084, 32'hCAFE_F00D, 32'h0000_0000, 32'h0000_0000, CP_BOOT},
   '{RD, 12'h004, 32'h0000_0000, 32'h1C00_8000, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h070, 32'h0000_0000, 32'h0000_0006, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h07C, 32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h080, 32'h0000_0000, 32'hDEAD_BEEF, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h084, 32'h0000_0000, 32'hCAFE_F00D, 32'hFFFF_FFFF, CP_NONE},
   '{WR, 12'h008, 32'h0000_0001, 32'h0000_0000, 32'h0000_0000, CP_FETCH},   // fc fetch enable
   '{RD, 12'h008, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFFF, CP_NONE},    // write only
   '{WR, 12'h0A0, 32'h8000_1234, 32'h0000_0000, 32'h0000_0000, CP_NONE},    // core status
   '{WR, 12'h0C0, 32'h0000_FFFF, 32'h0000_0000, 32'h0000_0000, CP_NONE},    // mirror ignores it
   '{RD, 12'h0A0, 32'h0000_0000, 32'h8000_1234, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h0C0, 32'h0000_0000, 32'h8000_1234, 32'hFFFF_FFFF, CP_NONE},
   '{WR, 12'h074, 32'h0000_003C, 32'h0000_0000, 32'h0000_0000, CP_JTAG},    // jtag exchange
   '{RD, 12'h074, 32'h0000_0000, 32'h0000_A53C, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h0C4, 32'h0000_0000, 32'h0000_0002, 32'hFFFF_FFFF, CP_NONE},    // boot select
   '{RD, 12'h0C8, 32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF, CP_NONE},    // clock select
   '{WR, 12'h00C, 32'h1111_1111, 32'h0000_0000, 32'h0000_0000, CP_NONE},    // unmapped words
   '{WR, 12'h078, 32'h2222_2222, 32'h0000_0000, 32'h0000_0000, CP_NONE},
   '{WR, 12'h0F0, 32'h3333_3333, 32'h0000_0000, 32'h0000_0000, CP_NONE},
   '{RD, 12'h00C, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h078, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h0F0, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h004, 32'h0000_0000, 32'h1C00_8000, 32'hFFFF_FFFF, CP_NONE},    // still intact
   '{RD, 12'h0A0, 32'h0000_0000, 32'h8000_1234, 32'hFFFF_FFFF, CP_NONE},
   '{RD, 12'h014, 32'h0000_0000, 32'hE4E4_E4E4, 32'hFFFF_FFFF, CP_NONE}
};

`endif

/* bench/tb_apb_soc_ctrl.sv */
/*
 * testbench of the APB system control register block
 *  - clock, reset and input defaults
 *  - table-driven APB transfers with masked read-data compare
 *  - output port checks at checkpoints of the table
 *  - cycle limit on the whole run
 */
`timescale 1ns/100ps

module tb_apb_soc_ctrl;
   import soc_ctrl_pkg::*;

   `include "tb_vectors.svh"

   localparam int unsigned TIMEOUT_CYCLES = NUM_VEC * 4 + 200;

   logic                  HCLK;
   logic                  HRESETn;
   apb_addr_t             paddr;
   word_t                 pwdata;
   logic                  pwrite;
   logic                  psel;
   logic                  penable;
   word_t                 prdata;
   logic                  pready;
   logic                  pslverr;
   logic                  sel_fll_clk;
   logic            [1:0] bootsel;
   logic                  fetch_en_valid;
   logic                  fetch_en;
   logic            [7:0] jtag_in;
   logic            [7:0] jtag_out;
   pad_fun_t       [63:0] pad_mux;
   logic      [63:0][5:0] pad_cfg;
   word_t                 fc_bootaddr;
   logic                  fc_fetchen;
   logic                  cluster_pow;
   logic                  cluster_byp;
   cluster_boot_t         cluster_boot_addr;
   logic                  cluster_fetch_enable;
   logic                  cluster_rstn;
   logic                  cluster_irq;
   int unsigned           cycle_count = 0;

   apb_soc_ctrl u_dut (
      .HCLK                   (HCLK),
      .HRESETn                (HRESETn),
      .PADDR_i                (paddr),
      .PWDATA_i               (pwdata),
      .PWRITE_i               (pwrite),
      .PSEL_i                 (psel),
      .PENABLE_i              (penable),
      .PRDATA_o               (prdata),
      .PREADY_o               (pready),
      .PSLVERR_o              (pslverr),
      .sel_fll_clk_i          (sel_fll_clk),
      .bootsel_i              (bootsel),
      .fc_fetch_en_valid_i    (fetch_en_valid),
      .fc_fetch_en_i          (fetch_en),
      .soc_jtag_reg_i         (jtag_in),
      .pad_mux_o              (pad_mux),
      .pad_cfg_o              (pad_cfg),
      .soc_jtag_reg_o         (jtag_out),
      .fc_bootaddr_o          (fc_bootaddr),
      .fc_fetchen_o           (fc_fetchen),
      .cluster_pow_o          (cluster_pow),
      .cluster_byp_o          (cluster_byp),
      .cluster_boot_addr_o    (cluster_boot_addr),
      .cluster_fetch_enable_o (cluster_fetch_enable),
      .cluster_rstn_o         (cluster_rstn),
      .cluster_irq_o          (cluster_irq)
   );

   initial
   begin
      HCLK = 1'b0;
      forever #50 HCLK = ~HCLK;  // 100 ns period
   end

   task automatic fail_run(input string reason);
      $display("%s", reason);
      $display("Test failures found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected)
         fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, actual, expected));
   endtask

   // setup and access phase, sampled mid-cycle
   task automatic apb_transfer(input vec_t v);
      @(posedge HCLK);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= v.wr;
      paddr   <= v.addr;
      pwdata  <= v.wdata;
      @(posedge HCLK);
      penable <= 1'b1;
      @(negedge HCLK);
      check_value("PREADY", 64'(pready), 64'h1);
      check_value("PSLVERR", 64'(pslverr), 64'h0);
      if (!v.wr)
         check_value($sformatf("PRDATA at %h", v.addr), 64'(prdata & v.mask),
                     64'(v.exp & v.mask));
   endtask

   task automatic pulse_fetch_override(input logic en);
      @(posedge HCLK);
      fetch_en_valid <= 1'b1;
      fetch_en       <= en;
      @(posedge HCLK);
      fetch_en_valid <= 1'b0;
      @(negedge HCLK);
   endtask

   // bus idle for one cycle so the last write reaches the outputs
   task automatic run_checkpoint(input logic [2:0] cp);
      @(posedge HCLK);
      psel    <= 1'b0;
      penable <= 1'b0;
      @(negedge HCLK);
      case (cp)
         CP_RESET:
         begin
            check_value("fc_fetchen", 64'(fc_fetchen), 64'h0);
            check_value("fc_bootaddr", 64'(fc_bootaddr), 64'h1A00_0080);
            check_value("cluster_pow", 64'(cluster_pow), 64'h0);
            check_value("cluster_fetch_enable", 64'(cluster_fetch_enable), 64'h0);
            check_value("cluster_irq", 64'(cluster_irq), 64'h0);
            check_value("cluster_byp", 64'(cluster_byp), 64'h1);
            check_value("cluster_rstn", 64'(cluster_rstn), 64'h1);
            check_value("cluster_boot_addr", cluster_boot_addr, 64'h0);
            check_value("soc_jtag_reg_o", 64'(jtag_out), 64'h0);
            for (int i = 0; i < 64; i++)
            begin
               check_value($sformatf("pad_mux[%0d]", i), 64'(pad_mux[i]), 64'h0);
               check_value($sformatf("pad_cfg[%0d]", i), 64'(pad_cfg[i]), 64'h3F);
            end
            @(posedge HCLK);
            bootsel     <= 2'b10;  // held for the rest of the run
            sel_fll_clk <= 1'b1;
            jtag_in     <= 8'hA5;
         end
         CP_PADMUX:
         begin
            check_value("pad_mux[1]", 64'(pad_mux[1]), 64'h2);
            check_value("pad_mux[17]", 64'(pad_mux[17]), 64'h1);
            check_value("pad_mux[36]", 64'(pad_mux[36]), 64'h1);
            check_value("pad_mux[40]", 64'(pad_mux[40]), 64'h2);
            check_value("pad_mux[48]", 64'(pad_mux[48]), 64'h0);
            check_value("pad_mux[63]", 64'(pad_mux[63]), 64'h3);
         end
         CP_PADCFG:
         begin
            check_value("pad_cfg[0]", 64'(pad_cfg[0]), 64'h3F);
            check_value("pad_cfg[4]", 64'(pad_cfg[4]), 64'h3F);
            check_value("pad_cfg[29]", 64'(pad_cfg[29]), 64'h16);
            check_value("pad_cfg[60]", 64'(pad_cfg[60]), 64'h3C);
            check_value("pad_cfg[63]", 64'(pad_cfg[63]), 64'h25);
         end
         CP_BOOT:
         begin
            check_value("fc_bootaddr", 64'(fc_bootaddr), 64'h1C00_8000);
            check_value("cluster_byp", 64'(cluster_byp), 64'h0);
            check_value("cluster_pow", 64'(cluster_pow), 64'h1);
            check_value("cluster_fetch_enable", 64'(cluster_fetch_enable), 64'h1);
            check_value("cluster_rstn", 64'(cluster_rstn), 64'h0);
            check_value("cluster_irq", 64'(cluster_irq), 64'h1);
            check_value("cluster_boot_addr", cluster_boot_addr, 64'hCAFE_F00D_DEAD_BEEF);
         end
         CP_FETCH:
         begin
            check_value("fc_fetchen after write", 64'(fc_fetchen), 64'h1);
            pulse_fetch_override(1'b0);
            check_value("fc_fetchen after override", 64'(fc_fetchen), 64'h0);
            pulse_fetch_override(1'b1);
            check_value("fc_fetchen after override", 64'(fc_fetchen), 64'h1);
         end
         CP_JTAG:
            check_value("soc_jtag_reg_o", 64'(jtag_out), 64'h3C);
         default: ;
      endcase
   endtask

   always @(posedge HCLK)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
         fail_run("the run timed out before all table entries were done");
   end

   initial
   begin
      HRESETn        = 1'b0;
      paddr          = '0;
      pwdata         = '0;
      pwrite         = 1'b0;
      psel           = 1'b0;
      penable        = 1'b0;
      sel_fll_clk    = 1'b0;
      bootsel        = 2'b00;
      fetch_en_valid = 1'b0;
      fetch_en       = 1'b0;
      jtag_in        = '0;
      repeat (4) @(posedge HCLK);
      HRESETn <= 1'b1;
      for (int n = 0; n < NUM_VEC; n++)
      begin
         apb_transfer(vectors[n]);
         if (vectors[n].cp != CP_NONE)
            run_checkpoint(vectors[n].cp);
      end
      @(posedge HCLK);
      psel    <= 1'b0;
      penable <= 1'b0;
      @(negedge HCLK);
      $display("All tests passed!");
      $finish;
   end

endmodule

/* build.f */
+incdir+bench
common/soc_ctrl_pkg.sv
pads/pad_mux_regs.sv
pads/pad_cfg_regs.sv
rtl/boot_ctrl_regs.sv
rtl/status_regs.sv
rtl/apb_soc_ctrl.sv
bench/tb_apb_soc_ctrl.sv

/* Makefile */
# Verilator build and run of the APB system control testbench

TOP := tb_apb_soc_ctrl

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 -f build.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir
